// ==== adc_frontend.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

module adc_frontend (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  sdr_pkg::adc_sample_t adc_data_i,
    input  logic                 dor_i,
    reg_bus_if.peer              bus,
    output sdr_pkg::adc_sample_t sample_o,
    output sdr_pkg::adc_io_t     adc_io_o
);
    import sdr_pkg::*;

    logic [1:0] att_q;      // Attenuator steps
    logic       amp_en_q;
    logic [2:0] led_q;      // Red, green1, green0
    logic       dor_q;
    logic       ovr_q;      // Sticky overrange
    logic       wr_acc;

    assign wr_acc = bus.sel && bus.enable && bus.write;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            att_q    <= '0;
            amp_en_q <= 1'b0;
            led_q    <= '0;
            dor_q    <= 1'b0;
            ovr_q    <= 1'b0;
            adc_io_o <= 8'hEC;      // All LEDs and attenuators off
        end else begin
            dor_q <= dor_i;
            if (wr_acc && bus.addr[11:0] == `ADC_CTRL) begin
                att_q    <= bus.wdata[1:0];
                amp_en_q <= bus.wdata[2];
                led_q    <= bus.wdata[6:4];
            end
            // Set wins over a clear in the same cycle
            if (dor_q)
                ovr_q <= 1'b1;
            else if (wr_acc && bus.addr[11:0] == `ADC_STATUS && bus.wdata[0])
                ovr_q <= 1'b0;

            // Overrange forces red on and greens off
            adc_io_o.red_n  <= !(dor_i || led_q[2]);
            adc_io_o.grn1_n <= !(!dor_i && led_q[1]);
            adc_io_o.grn0_n <= !(!dor_i && led_q[0]);
            adc_io_o.amp_en <= amp_en_q;
            adc_io_o.att1_n <= !att_q[1];
            adc_io_o.att0_n <= !att_q[0];
            adc_io_o.rsvd   <= '0;
        end
    end

    // Sample pipe, one stage
    always_ff @(posedge clk) begin
        sample_o <= adc_data_i;
    end

    always_comb begin
        bus.rdata = '0;
        case (bus.addr[11:0])
            `ADC_CTRL:   bus.rdata[6:0] = {led_q, 1'b0, amp_en_q, att_q};
            `ADC_STATUS: bus.rdata[0]   = ovr_q;
            default: ;
        endcase
    end

endmodule

// ==== compile.f ====
+incdir+.
sdr_pkg.sv
reg_bus_if.sv
reg_fabric.sv
ctrl_regs.sv
adc_frontend.sv
usb_tx_select.sv
led_ddac.sv
sdr_top.sv
tb_sdr_top.sv

// ==== ctrl_regs.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

module ctrl_regs (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                usb_wr_full_i,
    input  logic                usb_rd_empty_i,
    input  sdr_pkg::usb_word_t  usb_rd_data_i,
    reg_bus_if.peer             bus,
    output sdr_pkg::usb_word_t  cpu_wr_data_o,
    output sdr_pkg::usb_be_t    cpu_wr_be_o,
    output logic                cpu_wr_stb_o,
    output logic                cpu_rd_stb_o,
    output sdr_pkg::usb_mode_t  usb_mode_o,
    output sdr_pkg::led_level_t led0_level_o,
    output sdr_pkg::led_level_t led1_level_o
);
    import sdr_pkg::*;

    logic [11:0] offs;
    logic        wr_acc;
    logic        rd_acc;
    usb_word_t   wdata_q;   // Last CPU USB word

    assign offs   = bus.addr[11:0];
    assign wr_acc = bus.sel && bus.enable && bus.write;
    assign rd_acc = bus.sel && bus.enable && !bus.write;

    //////////////////////////////////////////////////////////////////////
    // CPU USB strobes, high during the access cycle only
    //////////////////////////////////////////////////////////////////////
    assign cpu_wr_stb_o = wr_acc && (offs == `CTRL_USB_WDATA);
    assign cpu_rd_stb_o = rd_acc && (offs == `CTRL_USB_RDATA);

    // New word bypasses the register so the selector catches it
    assign cpu_wr_data_o = cpu_wr_stb_o ? bus.wdata : wdata_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wdata_q      <= '0;
            cpu_wr_be_o  <= '0;
            usb_mode_o   <= USB_CPU;
            led0_level_o <= '0;     // LEDs dark
            led1_level_o <= '0;
        end else if (wr_acc) begin
            case (offs)
                `CTRL_USB_WDATA: wdata_q      <= bus.wdata;
                `CTRL_USB_BE:    cpu_wr_be_o  <= bus.wdata[`USB_BE_W-1:0];
                `CTRL_USB_MUX:   usb_mode_o   <= usb_mode_t'(bus.wdata[1:0]);
                `CTRL_LED0:      led0_level_o <= bus.wdata[`LED_DEPTH-1:0];
                `CTRL_LED1:      led1_level_o <= bus.wdata[`LED_DEPTH-1:0];
                default: ;                  // STATUS and RDATA read-only
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        bus.rdata = '0;
        case (offs)
            `CTRL_USB_WDATA: bus.rdata = wdata_q;
            `CTRL_USB_BE:    bus.rdata[`USB_BE_W-1:0] = cpu_wr_be_o;
            `CTRL_USB_MUX:   bus.rdata[1:0] = usb_mode_o;
            `CTRL_LED0:      bus.rdata[`LED_DEPTH-1:0] = led0_level_o;
            `CTRL_LED1:      bus.rdata[`LED_DEPTH-1:0] = led1_level_o;
            `CTRL_STATUS: begin
                bus.rdata[0] = usb_wr_full_i;
                bus.rdata[1] = usb_rd_empty_i;
            end
            `CTRL_USB_RDATA: bus.rdata = usb_rd_data_i;   // Live FIFO head
            default: ;
        endcase
    end

endmodule

// ==== led_ddac.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

module led_ddac #(
    parameter int DEPTH = `LED_DEPTH
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [DEPTH-1:0] level_i,
    output logic             pwm_o
);

    logic [DEPTH-1:0] acc_q;
    logic [DEPTH:0]   sum;      // Extra bit is the carry

    // First-order modulator, carry density tracks level
    assign sum = {1'b0, acc_q} + {1'b0, level_i};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
            pwm_o <= 1'b0;
        end else begin
            acc_q <= sum[DEPTH-1:0];
            pwm_o <= sum[DEPTH];
        end
    end

endmodule

// ==== reg_bus_if.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

interface reg_bus_if;

    logic                   sel;        // Decoded per peer
    logic                   enable;     // High in access cycle
    logic                   write;
    logic [`SDR_ADDR_W-1:0] addr;
    logic [`SDR_DATA_W-1:0] wdata;
    logic [`SDR_DATA_W-1:0] rdata;      // Peer read data, comb

    // Decoder side
    modport fabric (
        output sel, enable, write, addr, wdata,
        input  rdata
    );

    // Register block side
    modport peer (
        input  sel, enable, write, addr, wdata,
        output rdata
    );

endinterface

// ==== reg_fabric.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

module reg_fabric (
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`SDR_ADDR_W-1:0] paddr_i,
    input  logic [`SDR_DATA_W-1:0] pwdata_i,
    output logic [`SDR_DATA_W-1:0] prdata_o,
    reg_bus_if.fabric              adca_bus,
    reg_bus_if.fabric              adcb_bus,
    reg_bus_if.fabric              ctrl_bus
);

    logic       base_hit;   // Our 64 KB window
    logic [3:0] blk;

    assign base_hit = psel_i && (paddr_i[31:16] == `SDR_BUS_BASE);
    assign blk      = paddr_i[15:12];

    // Peer selects
    assign adca_bus.sel = base_hit && (blk == `SDR_BLK_ADCA);
    assign adcb_bus.sel = base_hit && (blk == `SDR_BLK_ADCB);
    assign ctrl_bus.sel = base_hit && (blk == `SDR_BLK_CTRL);

    // Shared fields go to every peer
    assign adca_bus.enable = penable_i;
    assign adca_bus.write  = pwrite_i;
    assign adca_bus.addr   = paddr_i;
    assign adca_bus.wdata  = pwdata_i;
    assign adcb_bus.enable = penable_i;
    assign adcb_bus.write  = pwrite_i;
    assign adcb_bus.addr   = paddr_i;
    assign adcb_bus.wdata  = pwdata_i;
    assign ctrl_bus.enable = penable_i;
    assign ctrl_bus.write  = pwrite_i;
    assign ctrl_bus.addr   = paddr_i;
    assign ctrl_bus.wdata  = pwdata_i;

    // Read return, zero on a miss
    always_comb begin
        prdata_o = '0;
        if (adca_bus.sel)
            prdata_o = adca_bus.rdata;
        else if (adcb_bus.sel)
            prdata_o = adcb_bus.rdata;
        else if (ctrl_bus.sel)
            prdata_o = ctrl_bus.rdata;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build tb_sdr_top with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_sdr_top -o tb_sdr_top \
    && ./obj_dir/tb_sdr_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sdr_params.svh ====
`ifndef SDR_PARAMS_SVH
`define SDR_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus map
//////////////////////////////////////////////////////////////////////
`define SDR_BUS_BASE    16'h43C0   // paddr[31:16]
`define SDR_BLK_ADCA    4'h0       // paddr[15:12]
`define SDR_BLK_ADCB    4'h1
`define SDR_BLK_CTRL    4'h4
`define SDR_ADDR_W      32
`define SDR_DATA_W      32

// Control block offsets
`define CTRL_USB_WDATA  12'h000
`define CTRL_USB_BE     12'h004
`define CTRL_USB_MUX    12'h008
`define CTRL_LED0       12'h00C
`define CTRL_LED1       12'h010
`define CTRL_STATUS     12'h014    // Bit 0 wr full, bit 1 rd empty
`define CTRL_USB_RDATA  12'h018

// ADC channel offsets
`define ADC_CTRL        12'h000
`define ADC_STATUS      12'h004

//////////////////////////////////////////////////////////////////////
// Widths and codes
//////////////////////////////////////////////////////////////////////
`define ADC_SAMPLE_W    8
`define USB_BE_W        4
`define LED_DEPTH       16

`define USB_MODE_CPU    2'd0
`define USB_MODE_IDLE   2'd1
`define USB_MODE_ADC    2'd2
`define USB_MODE_LOOP   2'd3

`endif

// ==== sdr_pkg.sv ====
`include "sdr_params.svh"

package sdr_pkg;

    // FT601 write source
    typedef enum logic [1:0] {
        USB_CPU  = `USB_MODE_CPU,   // Software words
        USB_IDLE = `USB_MODE_IDLE,
        USB_ADC  = `USB_MODE_ADC,   // Channel A stream
        USB_LOOP = `USB_MODE_LOOP   // Read side turned around
    } usb_mode_t;

    typedef logic [`ADC_SAMPLE_W-1:0] adc_sample_t;
    typedef logic [`SDR_DATA_W-1:0]   usb_word_t;
    typedef logic [`USB_BE_W-1:0]     usb_be_t;
    typedef logic [`LED_DEPTH-1:0]    led_level_t;

    // IO-expander byte, active-low LED and attenuator lines
    typedef struct packed {
        logic       red_n;
        logic       grn1_n;
        logic       grn0_n;
        logic       amp_en;     // Active high
        logic       att1_n;
        logic       att0_n;
        logic [1:0] rsvd;       // Tied low
    } adc_io_t;

endpackage

// ==== sdr_top.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

module sdr_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`SDR_ADDR_W-1:0] paddr_i,
    input  logic [`SDR_DATA_W-1:0] pwdata_i,
    output logic [`SDR_DATA_W-1:0] prdata_o,
    input  sdr_pkg::adc_sample_t   adc_a_data_i,
    input  logic                   adc_a_dor_i,
    input  sdr_pkg::adc_sample_t   adc_b_data_i,
    input  logic                   adc_b_dor_i,
    output sdr_pkg::adc_io_t       adc_a_io_o,
    output sdr_pkg::adc_io_t       adc_b_io_o,
    input  sdr_pkg::usb_word_t     usb_rd_data_i,
    input  sdr_pkg::usb_be_t       usb_rd_be_i,
    input  logic                   usb_rd_valid_i,
    input  logic                   usb_rd_empty_i,
    input  logic                   usb_wr_full_i,
    output sdr_pkg::usb_word_t     usb_wr_data_o,
    output sdr_pkg::usb_be_t       usb_wr_be_o,
    output logic                   usb_wr_en_o,
    output logic                   usb_rd_en_o,
    output logic                   led0_o,
    output logic                   led1_o
);
    import sdr_pkg::*;

    usb_word_t   cpu_wr_data;
    usb_be_t     cpu_wr_be;
    logic        cpu_wr_stb;
    logic        cpu_rd_stb;
    usb_mode_t   usb_mode;
    led_level_t  led0_level;
    led_level_t  led1_level;
    adc_sample_t adc_a_sample;  // Feeds the USB stream

    reg_bus_if adca_bus ();
    reg_bus_if adcb_bus ();
    reg_bus_if ctrl_bus ();

    //////////////////////////////////////////////////////////////////////
    // Register bus
    //////////////////////////////////////////////////////////////////////
    reg_fabric u_fabric (
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .adca_bus  (adca_bus),
        .adcb_bus  (adcb_bus),
        .ctrl_bus  (ctrl_bus)
    );

    ctrl_regs u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .usb_wr_full_i  (usb_wr_full_i),
        .usb_rd_empty_i (usb_rd_empty_i),
        .usb_rd_data_i  (usb_rd_data_i),
        .bus            (ctrl_bus),
        .cpu_wr_data_o  (cpu_wr_data),
        .cpu_wr_be_o    (cpu_wr_be),
        .cpu_wr_stb_o   (cpu_wr_stb),
        .cpu_rd_stb_o   (cpu_rd_stb),
        .usb_mode_o     (usb_mode),
        .led0_level_o   (led0_level),
        .led1_level_o   (led1_level)
    );

    //////////////////////////////////////////////////////////////////////
    // ADC front ends
    //////////////////////////////////////////////////////////////////////
    adc_frontend u_adca (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .adc_data_i (adc_a_data_i),
        .dor_i      (adc_a_dor_i),
        .bus        (adca_bus),
        .sample_o   (adc_a_sample),
        .adc_io_o   (adc_a_io_o)
    );

    adc_frontend u_adcb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .adc_data_i (adc_b_data_i),
        .dor_i      (adc_b_dor_i),
        .bus        (adcb_bus),
        .sample_o   (),             // B samples not streamed
        .adc_io_o   (adc_b_io_o)
    );

    //////////////////////////////////////////////////////////////////////
    // USB write source and LEDs
    //////////////////////////////////////////////////////////////////////
    usb_tx_select u_usb_sel (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .usb_mode_i     (usb_mode),
        .cpu_wr_data_i  (cpu_wr_data),
        .cpu_wr_be_i    (cpu_wr_be),
        .cpu_wr_stb_i   (cpu_wr_stb),
        .cpu_rd_stb_i   (cpu_rd_stb),
        .adc_sample_i   (adc_a_sample),
        .usb_rd_data_i  (usb_rd_data_i),
        .usb_rd_be_i    (usb_rd_be_i),
        .usb_rd_valid_i (usb_rd_valid_i),
        .usb_wr_full_i  (usb_wr_full_i),
        .usb_wr_data_o  (usb_wr_data_o),
        .usb_wr_be_o    (usb_wr_be_o),
        .usb_wr_en_o    (usb_wr_en_o),
        .usb_rd_en_o    (usb_rd_en_o)
    );

    led_ddac #(.DEPTH(`LED_DEPTH)) u_led0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .level_i (led0_level),
        .pwm_o   (led0_o)
    );

    led_ddac #(.DEPTH(`LED_DEPTH)) u_led1 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .level_i (led1_level),
        .pwm_o   (led1_o)
    );

endmodule

// ==== tb_sdr_top.sv ====
`timescale 1ns/1ps
`include "sdr_params.svh"

module tb_sdr_top;
    import sdr_pkg::*;

    localparam int HALF_PERIOD     = 4;     // 8 ns clock
    localparam int RESET_CYCLES    = 8;
    localparam int WATCHDOG_CYCLES = 4000;  // Sequence needs about 1600 cycles

    logic        clk = 1'b0;
    logic        rst_n_i, psel_i, penable_i, pwrite_i;
    logic [31:0] paddr_i, pwdata_i, prdata_o;
    adc_sample_t adc_a_data_i, adc_b_data_i;
    logic        adc_a_dor_i, adc_b_dor_i;
    adc_io_t     adc_a_io_o, adc_b_io_o;
    usb_word_t   usb_rd_data_i, usb_wr_data_o;
    usb_be_t     usb_rd_be_i, usb_wr_be_o;
    logic        usb_rd_valid_i, usb_rd_empty_i, usb_wr_full_i;
    logic        usb_wr_en_o, usb_rd_en_o, led0_o, led1_o;

    integer      seed = 29668;
    int          errors = 0;
    int          reg_checks = 0;
    int          i, w, ones;
    logic [31:0] rnd, rnd2;
    logic [1:0]  stat;

    // Reference model state
    logic        chk_io = 1'b0, chk_usb = 1'b0, chk_led0 = 1'b0;
    usb_mode_t   tb_mode = USB_CPU;
    logic [6:0]  set_a = '0, set_b = '0;   // ADC_CTRL as written
    usb_be_t     be_model = '0;
    logic        dor_a_q, dor_b_q, rd_valid_q, wr_full_q, wr_acc_q, rd_acc_q;
    adc_sample_t adc_a_q1, adc_a_q2;
    usb_word_t   rd_data_q, word_q, exp_wr_data;
    usb_be_t     rd_be_q, exp_wr_be;
    logic        exp_wr_en, exp_rd_en;
    logic [7:0]  exp_io_a, exp_io_b;

    sdr_top u_dut (.*);

    always #(HALF_PERIOD) clk = ~clk;

    function automatic logic [31:0] ctrl_addr(input logic [11:0] offs);
        return {`SDR_BUS_BASE, `SDR_BLK_CTRL, offs};
    endfunction

    function automatic logic [31:0] adc_addr(input logic [3:0] blk, input logic [11:0] offs);
        return {`SDR_BUS_BASE, blk, offs};
    endfunction

    // Access cycle hitting one control offset
    function automatic logic ctrl_access(input logic wr, input logic [11:0] offs);
        return psel_i && penable_i && (pwrite_i == wr) && (paddr_i == ctrl_addr(offs));
    endfunction

    // IO-expander byte from dor and ADC_CTRL bits
    function automatic logic [7:0] io_byte(input logic dor, input logic [6:0] set);
        logic [2:0] led;
        led = set[6:4];
        return {~(dor | led[2]), ~(~dor & led[1]), ~(~dor & led[0]),
                set[2], ~set[1], ~set[0], 2'b00};
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] got,
                                            input logic [31:0] exp);
        errors++;
        $display("MISMATCH %s got %h exp %h", name, got, exp);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        dor_a_q    <= adc_a_dor_i;
        dor_b_q    <= adc_b_dor_i;
        adc_a_q1   <= adc_a_data_i;     // Front-end register
        adc_a_q2   <= adc_a_q1;         // Selector register
        rd_data_q  <= usb_rd_data_i;
        rd_be_q    <= usb_rd_be_i;
        rd_valid_q <= usb_rd_valid_i;
        wr_full_q  <= usb_wr_full_i;
        wr_acc_q   <= ctrl_access(1'b1, `CTRL_USB_WDATA);
        rd_acc_q   <= ctrl_access(1'b0, `CTRL_USB_RDATA);
        if (ctrl_access(1'b1, `CTRL_USB_WDATA))
            word_q <= pwdata_i;
    end

    assign exp_io_a = io_byte(dor_a_q, set_a);
    assign exp_io_b = io_byte(dor_b_q, set_b);

    always_comb begin
        exp_wr_data = '0;           // IDLE leaves all zero
        exp_wr_be   = '0;
        exp_wr_en   = 1'b0;
        exp_rd_en   = 1'b0;
        case (tb_mode)
            USB_CPU: begin
                exp_wr_data = word_q;
                exp_wr_be   = be_model;
                exp_wr_en   = wr_acc_q;
                exp_rd_en   = rd_acc_q;
            end
            USB_ADC: begin
                exp_wr_data = {24'h0, adc_a_q2};
                exp_wr_be   = 4'hF;
                exp_wr_en   = 1'b1;
                exp_rd_en   = 1'b1;
            end
            USB_LOOP: begin
                exp_wr_data = rd_data_q;
                exp_wr_be   = rd_be_q;
                exp_wr_en   = rd_valid_q;
                exp_rd_en   = !wr_full_q;   // Reads stall on full
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (!rst_n_i) chk_io |-> adc_a_io_o == exp_io_a)
        else report_mismatch("adc_a_io_o", {24'h0, $sampled(adc_a_io_o)}, {24'h0, $sampled(exp_io_a)});
    assert property (@(posedge clk) disable iff (!rst_n_i) chk_io |-> adc_b_io_o == exp_io_b)
        else report_mismatch("adc_b_io_o", {24'h0, $sampled(adc_b_io_o)}, {24'h0, $sampled(exp_io_b)});
    assert property (@(posedge clk) disable iff (!rst_n_i) chk_usb |-> usb_wr_en_o == exp_wr_en)
        else report_mismatch("usb_wr_en_o", {31'h0, $sampled(usb_wr_en_o)}, {31'h0, $sampled(exp_wr_en)});
    assert property (@(posedge clk) disable iff (!rst_n_i) chk_usb |-> usb_rd_en_o == exp_rd_en)
        else report_mismatch("usb_rd_en_o", {31'h0, $sampled(usb_rd_en_o)}, {31'h0, $sampled(exp_rd_en)});
    // Data and byte enables only matter on a CPU pulse
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     chk_usb && (tb_mode != USB_CPU || exp_wr_en) |-> usb_wr_data_o == exp_wr_data)
        else report_mismatch("usb_wr_data_o", $sampled(usb_wr_data_o), $sampled(exp_wr_data));
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     chk_usb && (tb_mode != USB_CPU || exp_wr_en) |-> usb_wr_be_o == exp_wr_be)
        else report_mismatch("usb_wr_be_o", {28'h0, $sampled(usb_wr_be_o)}, {28'h0, $sampled(exp_wr_be)});
    assert property (@(posedge clk) disable iff (!rst_n_i) chk_led0 |-> !led0_o)
        else report_mismatch("led0_o", {31'h0, $sampled(led0_o)}, 32'h0);

    //////////////////////////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel_i    <= 1'b1;          // Setup
        penable_i <= 1'b0;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk);
        penable_i <= 1'b1;          // Access
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        data = prdata_o;            // Mid access cycle
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        bus_read(addr, data);
        reg_checks++;
        assert (data == exp)
            else report_mismatch($sformatf("prdata_o[%h]", addr), data, exp);
    endtask

    task automatic write_readback(input logic [31:0] addr, input logic [31:0] mask);
        rnd = $random(seed);
        bus_write(addr, rnd);
        check_read(addr, rnd & mask);
    endtask

    // Fresh random values on every streaming input
    task automatic stream_random(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            rnd = $random(seed);
            adc_a_data_i   <= rnd[7:0];
            adc_b_data_i   <= rnd[15:8];
            adc_a_dor_i    <= rnd[16];
            adc_b_dor_i    <= rnd[17];
            usb_rd_be_i    <= rnd[21:18];
            usb_rd_valid_i <= rnd[22];
            usb_wr_full_i  <= rnd[23];
            usb_rd_empty_i <= rnd[24];
            rnd = $random(seed);
            usb_rd_data_i  <= rnd;
        end
    endtask

    task automatic run_mode(input usb_mode_t mode, input int cycles);
        bus_write(ctrl_addr(`CTRL_USB_MUX), {30'h0, mode});
        repeat (2) @(posedge clk);
        tb_mode <= mode;
        chk_usb <= 1'b1;
        stream_random(cycles);
        chk_usb <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        rst_n_i        <= 1'b0;
        psel_i         <= 1'b0;
        penable_i      <= 1'b0;
        pwrite_i       <= 1'b0;
        paddr_i        <= '0;
        pwdata_i       <= '0;
        adc_a_data_i   <= '0;
        adc_b_data_i   <= '0;
        adc_a_dor_i    <= 1'b0;
        adc_b_dor_i    <= 1'b0;
        usb_rd_data_i  <= '0;
        usb_rd_be_i    <= '0;
        usb_rd_valid_i <= 1'b0;
        usb_rd_empty_i <= 1'b1;
        usb_wr_full_i  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (adc_a_io_o == 8'hEC) else report_mismatch("adc_a_io_o", {24'h0, adc_a_io_o}, 32'hEC);
        assert (adc_b_io_o == 8'hEC) else report_mismatch("adc_b_io_o", {24'h0, adc_b_io_o}, 32'hEC);

        // Register map
        for (i = 0; i < 6; i++) begin
            write_readback(ctrl_addr(`CTRL_LED0), 32'hFFFF);
            write_readback(ctrl_addr(`CTRL_LED1), 32'hFFFF);
            write_readback(ctrl_addr(`CTRL_USB_MUX), 32'h3);
            write_readback(ctrl_addr(`CTRL_USB_BE), 32'hF);
            write_readback(adc_addr(`SDR_BLK_ADCA, `ADC_CTRL), 32'h77);
            write_readback(adc_addr(`SDR_BLK_ADCB, `ADC_CTRL), 32'h77);
        end
        check_read(adc_addr(4'h2, `ADC_CTRL), 32'h0);               // Empty block
        check_read({16'h43C1, `SDR_BLK_CTRL, `CTRL_LED0}, 32'h0);   // Wrong base

        // IO byte under random settings and dor
        for (i = 0; i < 6; i++) begin
            rnd = $random(seed);
            set_a = rnd[6:0] & 7'h77;
            set_b = rnd[14:8] & 7'h77;
            bus_write(adc_addr(`SDR_BLK_ADCA, `ADC_CTRL), {25'h0, set_a});
            bus_write(adc_addr(`SDR_BLK_ADCB, `ADC_CTRL), {25'h0, set_b});
            @(posedge clk);
            chk_io <= 1'b1;
            stream_random(16);
            chk_io <= 1'b0;
        end

        // Sticky overrange
        @(posedge clk);
        adc_a_dor_i <= 1'b0;
        adc_b_dor_i <= 1'b0;
        repeat (2) @(posedge clk);
        bus_write(adc_addr(`SDR_BLK_ADCA, `ADC_STATUS), 32'h1);
        bus_write(adc_addr(`SDR_BLK_ADCB, `ADC_STATUS), 32'h1);
        check_read(adc_addr(`SDR_BLK_ADCA, `ADC_STATUS), 32'h0);
        check_read(adc_addr(`SDR_BLK_ADCB, `ADC_STATUS), 32'h0);
        @(posedge clk);
        adc_a_dor_i <= 1'b1;        // One-cycle overrange
        adc_b_dor_i <= 1'b1;
        @(posedge clk);
        adc_a_dor_i <= 1'b0;
        adc_b_dor_i <= 1'b0;
        repeat (2) @(posedge clk);
        check_read(adc_addr(`SDR_BLK_ADCA, `ADC_STATUS), 32'h1);
        check_read(adc_addr(`SDR_BLK_ADCB, `ADC_STATUS), 32'h1);
        bus_write(adc_addr(`SDR_BLK_ADCA, `ADC_STATUS), 32'h1);
        bus_write(adc_addr(`SDR_BLK_ADCB, `ADC_STATUS), 32'h1);
        check_read(adc_addr(`SDR_BLK_ADCA, `ADC_STATUS), 32'h0);
        check_read(adc_addr(`SDR_BLK_ADCB, `ADC_STATUS), 32'h0);

        // CPU USB path
        bus_write(ctrl_addr(`CTRL_USB_MUX), {30'h0, USB_CPU});
        @(posedge clk);
        tb_mode <= USB_CPU;
        chk_usb <= 1'b1;
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            be_model = rnd[3:0];
            bus_write(ctrl_addr(`CTRL_USB_BE), {28'h0, rnd[3:0]});
            rnd = $random(seed);
            bus_write(ctrl_addr(`CTRL_USB_WDATA), rnd);
            check_read(ctrl_addr(`CTRL_USB_WDATA), rnd);
            rnd2 = $random(seed);
            @(posedge clk);
            usb_rd_data_i  <= rnd2;
            stat = 2'(i);
            usb_wr_full_i  <= stat[0];
            usb_rd_empty_i <= stat[1];
            check_read(ctrl_addr(`CTRL_USB_RDATA), rnd2);
            check_read(ctrl_addr(`CTRL_STATUS), {30'h0, stat});
        end
        @(posedge clk);
        chk_usb <= 1'b0;

        run_mode(USB_ADC, 40);
        run_mode(USB_IDLE, 20);
        run_mode(USB_LOOP, 60);

        // LED density, level 0x4000 is one carry in four
        bus_write(ctrl_addr(`CTRL_LED0), 32'h0);
        bus_write(ctrl_addr(`CTRL_LED1), 32'h4000);
        repeat (4) @(posedge clk);
        chk_led0 <= 1'b1;
        for (w = 0; w < 2; w++) begin
            ones = 0;
            repeat (256) begin
                @(negedge clk);
                if (led1_o)
                    ones++;
            end
            assert (ones >= 63 && ones <= 65)
                else report_mismatch("led1_o ones per 256", ones, 32'd64);
            repeat (37) @(posedge clk);     // Odd offset for the next window
        end
        @(posedge clk);
        chk_led0 <= 1'b0;

        @(posedge clk);
        $display("Summary: %0d errors, %0d register reads", errors, reg_checks);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== usb_tx_select.sv ====
`timescale 1ns/1ps

module usb_tx_select (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  sdr_pkg::usb_mode_t   usb_mode_i,
    input  sdr_pkg::usb_word_t   cpu_wr_data_i,
    input  sdr_pkg::usb_be_t     cpu_wr_be_i,
    input  logic                 cpu_wr_stb_i,
    input  logic                 cpu_rd_stb_i,
    input  sdr_pkg::adc_sample_t adc_sample_i,
    input  sdr_pkg::usb_word_t   usb_rd_data_i,
    input  sdr_pkg::usb_be_t     usb_rd_be_i,
    input  logic                 usb_rd_valid_i,
    input  logic                 usb_wr_full_i,
    output sdr_pkg::usb_word_t   usb_wr_data_o,
    output sdr_pkg::usb_be_t     usb_wr_be_o,
    output logic                 usb_wr_en_o,
    output logic                 usb_rd_en_o
);
    import sdr_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            usb_wr_data_o <= '0;
            usb_wr_be_o   <= '0;
            usb_wr_en_o   <= 1'b0;
            usb_rd_en_o   <= 1'b0;
        end else begin
            case (usb_mode_i)
                USB_CPU: begin
                    usb_wr_data_o <= cpu_wr_data_i;
                    usb_wr_be_o   <= cpu_wr_be_i;
                    usb_wr_en_o   <= cpu_wr_stb_i;
                    usb_rd_en_o   <= cpu_rd_stb_i;
                end
                USB_IDLE: begin
                    usb_wr_data_o <= '0;
                    usb_wr_be_o   <= '0;
                    usb_wr_en_o   <= 1'b0;
                    usb_rd_en_o   <= 1'b0;
                end
                USB_ADC: begin                                  // Free running, ignores full
                    usb_wr_data_o <= usb_word_t'(adc_sample_i); // Zero-extended
                    usb_wr_be_o   <= '1;
                    usb_wr_en_o   <= 1'b1;
                    usb_rd_en_o   <= 1'b1;
                end
                USB_LOOP: begin
                    usb_wr_data_o <= usb_rd_data_i;
                    usb_wr_be_o   <= usb_rd_be_i;
                    usb_wr_en_o   <= usb_rd_valid_i;
                    usb_rd_en_o   <= !usb_wr_full_i;    // Stall reads on full
                end
            endcase
        end
    end

endmodule
